//--- common/tank_pkg.sv
// ----------------------------------------------------------
// grid, timing and encoding constants for the enemy tank
// coordinates are 5 bits, so the grid may not exceed 32 cells
// on a side
// ----------------------------------------------------------
`default_nettype none

package tank_pkg;

	// ----------------------------------------------------------
	// types
	// ----------------------------------------------------------
	typedef logic [4:0] coord_t;       // grid cell index
	typedef logic [1:0] dir_t;         // facing
	typedef logic [1:0] slot_t;        // spawn corner
	typedef logic [4:0] score_t;       // kill count
	typedef logic [2:0] tick_cnt_t;    // divider countdown
	typedef logic [2:0] reward_cnt_t;  // reward countdown, in move ticks

	// facing encodings, up means decreasing y
	localparam dir_t DIR_UP    = 2'd0;
	localparam dir_t DIR_DOWN  = 2'd1;
	localparam dir_t DIR_LEFT  = 2'd2;
	localparam dir_t DIR_RIGHT = 2'd3;

	// ----------------------------------------------------------
	// grid
	// ----------------------------------------------------------
	localparam int GRID_W = 25;  // x runs 0..24
	localparam int GRID_H = 13;  // y runs 0..12

	localparam coord_t SPAWN0_X = 5'd0;
	localparam coord_t SPAWN0_Y = 5'd0;
	localparam coord_t SPAWN1_X = 5'd24;
	localparam coord_t SPAWN1_Y = 5'd0;
	localparam coord_t SPAWN2_X = 5'd0;
	localparam coord_t SPAWN2_Y = 5'd12;
	localparam coord_t SPAWN3_X = 5'd24;
	localparam coord_t SPAWN3_Y = 5'd12;

	// ----------------------------------------------------------
	// timing
	// ----------------------------------------------------------
	localparam int MOVE_DIV     = 4;  // clk cycles per move tick
	localparam int SHELL_DIV    = 2;  // clk cycles per shell tick
	localparam int REWARD_TICKS = 6;  // move ticks per freeze or laser grant

	localparam int SCORE_MAX = 31;  // score saturates here

endpackage

`default_nettype wire

//--- common/tank_pos_if.sv
// ----------------------------------------------------------
// enemy tank state as seen by the judge and the gun
// only the owner drives, everything else reads
// ----------------------------------------------------------
`default_nettype none

interface tank_pos_if;
	import tank_pkg::*;

	coord_t x;      // current cell
	coord_t y;
	dir_t   dir;    // last step direction
	logic   alive;
	logic   fire;   // lined up with the player

	modport owner (output x, y, dir, alive, fire);

	modport judge (input x, y, dir, alive);

	modport gunner (input x, y, dir, fire);

endinterface

`default_nettype wire

//--- enemy_tank/enemy_tank_ctrl.sv
// ----------------------------------------------------------
// respawn and chase FSM, one cell per move tick
// kill wins over a move in the same cycle
// player coordinates outside the grid are never chased past the edge
// ----------------------------------------------------------
`default_nettype none

module enemy_tank_ctrl
(
	input  logic            clk,
	input  logic            rst_n,
	input  logic            enable,
	input  logic            move_tick,
	input  logic            freeze,
	input  logic            kill,
	input  logic            respawn_req,
	input  tank_pkg::slot_t  spawn_slot,
	input  tank_pkg::coord_t player_x,
	input  tank_pkg::coord_t player_y,
	tank_pos_if.owner       pos
);
	import tank_pkg::*;

	typedef enum logic
	{
		DEAD,
		HUNT
	} state_t;

	state_t state;
	coord_t x_q;
	coord_t y_q;
	dir_t   dir_q;

	coord_t spawn_x;
	coord_t spawn_y;

	coord_t h_dis;
	coord_t v_dis;
	logic   same_col;
	logic   same_row;
	logic   on_cell;
	logic   go_h;
	logic   go_v;

	coord_t next_x;
	coord_t next_y;
	dir_t   next_dir;

	// ----------------------------------------------------------
	// relation to the player
	// ----------------------------------------------------------
	assign same_col = (x_q == player_x);
	assign same_row = (y_q == player_y);
	assign on_cell  = same_col && same_row;
	assign h_dis    = (x_q > player_x) ? (x_q - player_x) : (player_x - x_q);
	assign v_dis    = (y_q > player_y) ? (y_q - player_y) : (player_y - y_q);

	always_comb
	begin
		case (spawn_slot)
			2'd0:
			begin
				spawn_x = SPAWN0_X;
				spawn_y = SPAWN0_Y;
			end
			2'd1:
			begin
				spawn_x = SPAWN1_X;
				spawn_y = SPAWN1_Y;
			end
			2'd2:
			begin
				spawn_x = SPAWN2_X;
				spawn_y = SPAWN2_Y;
			end
			default:
			begin
				spawn_x = SPAWN3_X;
				spawn_y = SPAWN3_Y;
			end
		endcase
	end

	// ----------------------------------------------------------
	// chase rule
	// ----------------------------------------------------------
	always_comb
	begin
		go_h = 1'b0;
		go_v = 1'b0;
		if (on_cell)
			go_h = 1'b0;               // sit on the player
		else if (same_col)
			go_v = 1'b1;
		else if (same_row)
			go_h = 1'b1;
		else if (h_dis < v_dis)
			go_h = 1'b1;               // close the short gap first
		else
			go_v = 1'b1;

		next_x   = x_q;
		next_y   = y_q;
		next_dir = dir_q;
		if (go_h)
		begin
			if (player_x > x_q && x_q < coord_t'(GRID_W - 1))
			begin
				next_x   = x_q + 5'd1;
				next_dir = DIR_RIGHT;
			end
			else if (player_x < x_q)
			begin
				next_x   = x_q - 5'd1;
				next_dir = DIR_LEFT;
			end
		end
		if (go_v)
		begin
			if (player_y > y_q && y_q < coord_t'(GRID_H - 1))
			begin
				next_y   = y_q + 5'd1;
				next_dir = DIR_DOWN;
			end
			else if (player_y < y_q)
			begin
				next_y   = y_q - 5'd1;
				next_dir = DIR_UP;
			end
		end
	end

	// ----------------------------------------------------------
	// state and position
	// ----------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state <= DEAD;
			x_q   <= '0;
			y_q   <= '0;
			dir_q <= DIR_DOWN;
		end
		else if (enable)
		begin
			case (state)
				DEAD:
				begin
					if (respawn_req)
					begin
						state <= HUNT;
						x_q   <= spawn_x;
						y_q   <= spawn_y;
						dir_q <= DIR_DOWN;   // always enters facing down
					end
				end
				HUNT:
				begin
					if (kill)
						state <= DEAD;
					else if (move_tick && !freeze)
					begin
						x_q   <= next_x;
						y_q   <= next_y;
						dir_q <= next_dir;
					end
				end
				default:
					state <= DEAD;
			endcase
		end
	end

	assign pos.x     = x_q;
	assign pos.y     = y_q;
	assign pos.dir   = dir_q;
	assign pos.alive = (state == HUNT);
	assign pos.fire  = (state == HUNT) && (same_row || same_col) && !on_cell;

endmodule

`default_nettype wire

//--- enemy_tank/enemy_hit_judge.sv
// ----------------------------------------------------------
// body, bullet and laser hit detection plus the kill score
// kill is combinational and drops once the tank goes dead
// score holds at 0 while the game is disabled
// ----------------------------------------------------------
`default_nettype none

module enemy_hit_judge
(
	input  logic             clk,
	input  logic             rst_n,
	input  logic             enable,
	input  logic             laser,
	input  tank_pkg::coord_t player_x,
	input  tank_pkg::coord_t player_y,
	input  tank_pkg::dir_t   player_dir,
	input  logic             pbul_valid,
	input  tank_pkg::coord_t pbul_x,
	input  tank_pkg::coord_t pbul_y,
	tank_pos_if.judge        pos,
	output logic             kill,
	output tank_pkg::score_t score
);
	import tank_pkg::*;

	logic body_hit;
	logic bullet_hit;
	logic laser_hit;
	logic beam_col;
	logic beam_row;

	// ----------------------------------------------------------
	// hit conditions
	// ----------------------------------------------------------
	assign body_hit   = (pos.x == player_x) && (pos.y == player_y);
	assign bullet_hit = pbul_valid && (pos.x == pbul_x) && (pos.y == pbul_y);

	// beam runs from the player along its facing to the grid edge
	assign beam_col = (pos.x == player_x) &&
		((player_dir == DIR_UP && pos.y < player_y) ||
		 (player_dir == DIR_DOWN && pos.y > player_y));
	assign beam_row = (pos.y == player_y) &&
		((player_dir == DIR_LEFT && pos.x < player_x) ||
		 (player_dir == DIR_RIGHT && pos.x > player_x));
	assign laser_hit = laser && (beam_col || beam_row);

	assign kill = pos.alive && (body_hit || bullet_hit || laser_hit);

	// ----------------------------------------------------------
	// score
	// ----------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			score <= '0;
		else if (!enable)
			score <= '0;                             // cleared between games
		else if (kill && score != score_t'(SCORE_MAX))
			score <= score + 5'd1;                   // saturating
	end

endmodule

`default_nettype wire

//--- design/game_tick.sv
// ----------------------------------------------------------
// move and shell strobes from clk, one cycle wide
// counters restart while enable is low
// ----------------------------------------------------------
`default_nettype none

module game_tick
(
	input  logic clk,
	input  logic rst_n,
	input  logic enable,
	output logic move_tick,
	output logic shell_tick
);
	import tank_pkg::*;

	tick_cnt_t  cnt [2];  // 0 move, 1 shell
	logic [1:0] strobe;

	function automatic tick_cnt_t reload_val(input int unsigned idx);
		if (idx == 0)
			return tick_cnt_t'(MOVE_DIV - 1);
		return tick_cnt_t'(SHELL_DIV - 1);
	endfunction

	always_ff @(posedge clk)
	begin
		for (int unsigned i = 0; i < 2; i++)
		begin
			if (!rst_n || !enable)
			begin
				cnt[i]    <= reload_val(i);
				strobe[i] <= 1'b0;
			end
			else
			begin
				strobe[i] <= (cnt[i] == '0);
				cnt[i]    <= (cnt[i] == '0) ? reload_val(i) : cnt[i] - 3'd1;
			end
		end
	end

	assign move_tick  = strobe[0];
	assign shell_tick = strobe[1];

endmodule

`default_nettype wire

//--- design/reward_regs.sv
// ----------------------------------------------------------
// freeze and laser countdowns, measured in move ticks
// a new grant reloads the full count, also mid-countdown
// ----------------------------------------------------------
`default_nettype none

module reward_regs
(
	input  logic clk,
	input  logic rst_n,
	input  logic enable,
	input  logic move_tick,
	input  logic freeze_grant,
	input  logic laser_grant,
	output logic freeze,
	output logic laser
);
	import tank_pkg::*;

	reward_cnt_t cnt [2];  // 0 freeze, 1 laser
	logic [1:0]  grant;

	assign grant = {laser_grant, freeze_grant};

	// ----------------------------------------------------------
	// countdowns
	// ----------------------------------------------------------
	always_ff @(posedge clk)
	begin
		for (int unsigned i = 0; i < 2; i++)
		begin
			if (!rst_n || !enable)
				cnt[i] <= '0;
			else if (grant[i])
				cnt[i] <= reward_cnt_t'(REWARD_TICKS);  // grant beats the tick
			else if (move_tick && cnt[i] != '0)
				cnt[i] <= cnt[i] - 3'd1;
		end
	end

	assign freeze = (cnt[0] != '0);
	assign laser  = (cnt[1] != '0);

endmodule

`default_nettype wire

//--- design/enemy_shell.sv
// ----------------------------------------------------------
// single enemy shell, launched from the tank cell on fire
// travels one cell per shell tick until the edge or the player
// keeps flying after the tank dies
// ----------------------------------------------------------
`default_nettype none

module enemy_shell
(
	input  logic             clk,
	input  logic             rst_n,
	input  logic             enable,
	input  logic             shell_tick,
	input  tank_pkg::coord_t player_x,
	input  tank_pkg::coord_t player_y,
	tank_pos_if.gunner       pos,
	output logic             shell_valid,
	output tank_pkg::coord_t shell_x,
	output tank_pkg::coord_t shell_y,
	output logic             player_hit
);
	import tank_pkg::*;

	dir_t   shell_dir;
	coord_t step_x;
	coord_t step_y;
	logic   at_edge;

	// ----------------------------------------------------------
	// next cell along the flight line
	// ----------------------------------------------------------
	always_comb
	begin
		step_x  = shell_x;
		step_y  = shell_y;
		at_edge = 1'b0;
		case (shell_dir)
			DIR_UP:
			begin
				at_edge = (shell_y == '0);
				step_y  = shell_y - 5'd1;
			end
			DIR_DOWN:
			begin
				at_edge = (shell_y == coord_t'(GRID_H - 1));
				step_y  = shell_y + 5'd1;
			end
			DIR_LEFT:
			begin
				at_edge = (shell_x == '0);
				step_x  = shell_x - 5'd1;
			end
			default:
			begin
				at_edge = (shell_x == coord_t'(GRID_W - 1));
				step_x  = shell_x + 5'd1;
			end
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			shell_valid <= 1'b0;
			player_hit  <= 1'b0;
		end
		else
		begin
			player_hit <= 1'b0;                      // pulse only
			if (enable && shell_tick)
			begin
				if (!shell_valid)
					shell_valid <= pos.fire;
				else if (at_edge)
					shell_valid <= 1'b0;             // would leave the grid
				else if (step_x == player_x && step_y == player_y)
				begin
					shell_valid <= 1'b0;
					player_hit  <= 1'b1;
				end
			end
		end
	end

	// position and heading carry no reset, valid qualifies them
	always_ff @(posedge clk)
	begin
		if (enable && shell_tick)
		begin
			if (!shell_valid)
			begin
				shell_x   <= pos.x;
				shell_y   <= pos.y;
				shell_dir <= pos.dir;
			end
			else if (!at_edge)
			begin
				shell_x <= step_x;
				shell_y <= step_y;
			end
		end
	end

endmodule

`default_nettype wire

//--- design/tank_arena_top.sv
// ----------------------------------------------------------
// enemy tank, its shell and the score on a single clk
// player, bullet and rewards come in as plain levels and pulses
// ----------------------------------------------------------
`default_nettype none

module tank_arena_top
(
	input  logic             clk,
	input  logic             rst_n,
	input  logic             enable,
	input  logic             respawn_req,
	input  tank_pkg::slot_t  spawn_slot,
	input  tank_pkg::coord_t player_x,
	input  tank_pkg::coord_t player_y,
	input  tank_pkg::dir_t   player_dir,
	input  logic             pbul_valid,
	input  tank_pkg::coord_t pbul_x,
	input  tank_pkg::coord_t pbul_y,
	input  logic             freeze_grant,
	input  logic             laser_grant,
	output tank_pkg::coord_t enemy_x,
	output tank_pkg::coord_t enemy_y,
	output tank_pkg::dir_t   enemy_dir,
	output logic             enemy_alive,
	output tank_pkg::score_t score,
	output logic             shell_valid,
	output tank_pkg::coord_t shell_x,
	output tank_pkg::coord_t shell_y,
	output logic             player_hit
);

	logic move_tick;
	logic shell_tick;
	logic freeze;
	logic laser;
	logic kill;

	tank_pos_if pos_bus ();

	// ----------------------------------------------------------
	// timing and rewards
	// ----------------------------------------------------------
	game_tick u_game_tick
	(
		.clk        (clk),
		.rst_n      (rst_n),
		.enable     (enable),
		.move_tick  (move_tick),
		.shell_tick (shell_tick)
	);

	reward_regs u_reward_regs
	(
		.clk          (clk),
		.rst_n        (rst_n),
		.enable       (enable),
		.move_tick    (move_tick),
		.freeze_grant (freeze_grant),
		.laser_grant  (laser_grant),
		.freeze       (freeze),
		.laser        (laser)
	);

	// ----------------------------------------------------------
	// enemy tank, judge and shell
	// ----------------------------------------------------------
	enemy_tank_ctrl u_enemy_tank_ctrl
	(
		.clk         (clk),
		.rst_n       (rst_n),
		.enable      (enable),
		.move_tick   (move_tick),
		.freeze      (freeze),
		.kill        (kill),
		.respawn_req (respawn_req),
		.spawn_slot  (spawn_slot),
		.player_x    (player_x),
		.player_y    (player_y),
		.pos         (pos_bus.owner)
	);

	enemy_hit_judge u_enemy_hit_judge
	(
		.clk        (clk),
		.rst_n      (rst_n),
		.enable     (enable),
		.laser      (laser),
		.player_x   (player_x),
		.player_y   (player_y),
		.player_dir (player_dir),
		.pbul_valid (pbul_valid),
		.pbul_x     (pbul_x),
		.pbul_y     (pbul_y),
		.pos        (pos_bus.judge),
		.kill       (kill),
		.score      (score)
	);

	enemy_shell u_enemy_shell
	(
		.clk         (clk),
		.rst_n       (rst_n),
		.enable      (enable),
		.shell_tick  (shell_tick),
		.player_x    (player_x),
		.player_y    (player_y),
		.pos         (pos_bus.gunner),
		.shell_valid (shell_valid),
		.shell_x     (shell_x),
		.shell_y     (shell_y),
		.player_hit  (player_hit)
	);

	assign enemy_x     = pos_bus.x;
	assign enemy_y     = pos_bus.y;
	assign enemy_dir   = pos_bus.dir;
	assign enemy_alive = pos_bus.alive;

endmodule

`default_nettype wire

//--- tests/tank_arena_tb.sv
// ----------------------------------------------------------
// replays tests/tank_arena_tests.txt against tank_arena_top
// run from the project root so the scenario path resolves
// expected values assume MOVE_DIV 4, SHELL_DIV 2 and REWARD_TICKS 6
// ----------------------------------------------------------
`default_nettype none

module tank_arena_tb;
	timeunit 1ns;
	timeprecision 100ps;

	import tank_pkg::*;

	typedef struct packed
	{
		logic   enable;
		logic   respawn;
		slot_t  slot;
		coord_t px;
		coord_t py;
		dir_t   pdir;
		logic   bul_valid;
		coord_t bul_x;
		coord_t bul_y;
		logic   freeze_grant;
		logic   laser_grant;
		int     wait_cycles;   // edges with the new inputs before the check
		coord_t exp_x;
		coord_t exp_y;
		dir_t   exp_dir;
		logic   exp_alive;
		score_t exp_score;
		logic   exp_shell;
		logic   exp_hit;       // any player_hit during the wait
	} scenario_t;

	logic   clk;
	logic   rst_n;
	logic   enable;
	logic   respawn_req;
	slot_t  spawn_slot;
	coord_t player_x;
	coord_t player_y;
	dir_t   player_dir;
	logic   pbul_valid;
	coord_t pbul_x;
	coord_t pbul_y;
	logic   freeze_grant;
	logic   laser_grant;
	coord_t enemy_x;
	coord_t enemy_y;
	dir_t   enemy_dir;
	logic   enemy_alive;
	score_t score;
	logic   shell_valid;
	coord_t shell_x;
	coord_t shell_y;
	logic   player_hit;

	scenario_t scenarios [$];
	int        rec_num;
	int        cycle_limit;
	int        cycle_count;
	logic      loaded;
	logic      hit_seen;

	logic      shell_was_valid;   // values at the previous falling edge
	coord_t    shell_x_prev;
	coord_t    shell_y_prev;
	coord_t    tank_x_prev;
	coord_t    tank_y_prev;
	dir_t      tank_dir_prev;
	dir_t      shell_heading;     // enemy facing at launch

	tank_arena_top DUT
	(
		.clk          (clk),
		.rst_n        (rst_n),
		.enable       (enable),
		.respawn_req  (respawn_req),
		.spawn_slot   (spawn_slot),
		.player_x     (player_x),
		.player_y     (player_y),
		.player_dir   (player_dir),
		.pbul_valid   (pbul_valid),
		.pbul_x       (pbul_x),
		.pbul_y       (pbul_y),
		.freeze_grant (freeze_grant),
		.laser_grant  (laser_grant),
		.enemy_x      (enemy_x),
		.enemy_y      (enemy_y),
		.enemy_dir    (enemy_dir),
		.enemy_alive  (enemy_alive),
		.score        (score),
		.shell_valid  (shell_valid),
		.shell_x      (shell_x),
		.shell_y      (shell_y),
		.player_hit   (player_hit)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;   // 100 ns period
	end

	// ----------------------------------------------------------
	// compare tasks
	// ----------------------------------------------------------
	task automatic check_coord(input coord_t got, input coord_t exp, input string what);
		if (got !== exp)
		begin
			$display("[FAIL] %t record %0d: %s is %0d, expected %0d",
				$realtime, rec_num, what, got, exp);
			$display("Regression failed");
			$fatal(1, "coordinate mismatch");
		end
	endtask

	task automatic check_dir(input dir_t got, input dir_t exp, input string what);
		if (got !== exp)
		begin
			$display("[FAIL] %t record %0d: %s is %0d, expected %0d",
				$realtime, rec_num, what, got, exp);
			$display("Regression failed");
			$fatal(1, "direction mismatch");
		end
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what);
		if (got !== exp)
		begin
			$display("[FAIL] %t record %0d: %s is %b, expected %b",
				$realtime, rec_num, what, got, exp);
			$display("Regression failed");
			$fatal(1, "flag mismatch");
		end
	endtask

	task automatic check_score(input score_t got, input score_t exp);
		if (got !== exp)
		begin
			$display("[FAIL] %t record %0d: score is %0d, expected %0d",
				$realtime, rec_num, got, exp);
			$display("Regression failed");
			$fatal(1, "score mismatch");
		end
	endtask

	// ----------------------------------------------------------
	// shell flight, one cell per step along the launch facing
	// ----------------------------------------------------------
	function automatic coord_t ahead_x(input coord_t x, input dir_t d);
		if (d == DIR_LEFT)
			return x - 5'd1;
		if (d == DIR_RIGHT)
			return x + 5'd1;
		return x;
	endfunction

	function automatic coord_t ahead_y(input coord_t y, input dir_t d);
		if (d == DIR_UP)
			return y - 5'd1;   // up means decreasing y
		if (d == DIR_DOWN)
			return y + 5'd1;
		return y;
	endfunction

	always @(negedge clk)
	begin
		if (shell_valid === 1'b1)
		begin
			if (!shell_was_valid)
			begin
				check_coord(shell_x, tank_x_prev, "shell_x at launch");
				check_coord(shell_y, tank_y_prev, "shell_y at launch");
				shell_heading = tank_dir_prev;
			end
			else if (shell_x !== shell_x_prev || shell_y !== shell_y_prev)
			begin
				check_coord(shell_x, ahead_x(shell_x_prev, shell_heading), "shell_x in flight");
				check_coord(shell_y, ahead_y(shell_y_prev, shell_heading), "shell_y in flight");
			end
		end
		if (player_hit === 1'b1)
		begin
			check_bit(shell_was_valid, 1'b1, "shell in flight before player_hit");
			check_bit(shell_valid, 1'b0, "shell_valid after player_hit");
		end
		shell_was_valid = (shell_valid === 1'b1);
		shell_x_prev    = shell_x;
		shell_y_prev    = shell_y;
		tank_x_prev     = enemy_x;
		tank_y_prev     = enemy_y;
		tank_dir_prev   = enemy_dir;
	end

	// ----------------------------------------------------------
	// scenario file
	// ----------------------------------------------------------
	task automatic load_scenarios();
		int        fd;
		int        n;
		int        total;
		int        v [19];
		string     line;
		scenario_t s;
		fd = $fopen("tests/tank_arena_tests.txt", "r");
		if (fd == 0)
		begin
			$display("cannot open tests/tank_arena_tests.txt, run from the project root");
			$display("Regression failed");
			$fatal(1, "scenario file missing");
		end
		total = 0;
		while ($fgets(line, fd) > 0)
		begin
			if (line.len() == 0 || line.substr(0, 0) == "#")
				continue;                                    // comment line
			n = $sscanf(line, "%d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d",
				v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8], v[9],
				v[10], v[11], v[12], v[13], v[14], v[15], v[16], v[17], v[18]);
			if (n <= 0)
				continue;                                    // blank line
			if (n != 19)
			begin
				$display("scenario line has %0d fields instead of 19: %s", n, line);
				$display("Regression failed");
				$fatal(1, "bad scenario line");
			end
			s.enable       = (v[0] != 0);
			s.respawn      = (v[1] != 0);
			s.slot         = slot_t'(v[2]);
			s.px           = coord_t'(v[3]);
			s.py           = coord_t'(v[4]);
			s.pdir         = dir_t'(v[5]);
			s.bul_valid    = (v[6] != 0);
			s.bul_x        = coord_t'(v[7]);
			s.bul_y        = coord_t'(v[8]);
			s.freeze_grant = (v[9] != 0);
			s.laser_grant  = (v[10] != 0);
			s.wait_cycles  = v[11];
			s.exp_x        = coord_t'(v[12]);
			s.exp_y        = coord_t'(v[13]);
			s.exp_dir      = dir_t'(v[14]);
			s.exp_alive    = (v[15] != 0);
			s.exp_score    = score_t'(v[16]);
			s.exp_shell    = (v[17] != 0);
			s.exp_hit      = (v[18] != 0);
			scenarios.push_back(s);
			total += v[11];
		end
		$fclose(fd);
		if (scenarios.size() == 0)
		begin
			$display("no scenarios found in tests/tank_arena_tests.txt");
			$display("Regression failed");
			$fatal(1, "empty scenario file");
		end
		cycle_limit = 2 * total + 100;
	endtask

	task automatic apply_record(input scenario_t s);
		enable       <= s.enable;
		respawn_req  <= s.respawn;
		spawn_slot   <= s.slot;
		player_x     <= s.px;
		player_y     <= s.py;
		player_dir   <= s.pdir;
		pbul_valid   <= s.bul_valid;
		pbul_x       <= s.bul_x;
		pbul_y       <= s.bul_y;
		freeze_grant <= s.freeze_grant;
		laser_grant  <= s.laser_grant;
	endtask

	task automatic run_record(input scenario_t s);
		hit_seen = 1'b0;
		repeat (s.wait_cycles)
		begin
			@(posedge clk);
			respawn_req  <= 1'b0;   // one-cycle pulses
			freeze_grant <= 1'b0;
			laser_grant  <= 1'b0;
			@(negedge clk);
			if (player_hit)
				hit_seen = 1'b1;
		end
		check_coord(enemy_x, s.exp_x, "enemy_x");
		check_coord(enemy_y, s.exp_y, "enemy_y");
		check_dir(enemy_dir, s.exp_dir, "enemy_dir");
		check_bit(enemy_alive, s.exp_alive, "enemy_alive");
		check_score(score, s.exp_score);
		check_bit(shell_valid, s.exp_shell, "shell_valid");
		check_bit(hit_seen, s.exp_hit, "player_hit seen");
	endtask

	// ----------------------------------------------------------
	// watchdog and main sequence
	// ----------------------------------------------------------
	initial
	begin
		cycle_count = 0;
		wait (loaded === 1'b1);
		forever
		begin
			@(posedge clk);
			cycle_count++;
			if (cycle_count >= cycle_limit)
			begin
				$display("timeout after %0d clock cycles, the scenarios did not finish",
					cycle_count);
				$display("Regression failed");
				$fatal(1, "cycle limit reached");
			end
		end
	end

	initial
	begin
		$timeformat(-9, 1, " ns", 10);
		loaded          = 1'b0;
		shell_was_valid = 1'b0;
		rst_n           = 1'b0;
		enable          = 1'b0;
		respawn_req     = 1'b0;
		spawn_slot      = '0;
		player_x        = '0;
		player_y        = '0;
		player_dir      = DIR_UP;
		pbul_valid      = 1'b0;
		pbul_x          = '0;
		pbul_y          = '0;
		freeze_grant    = 1'b0;
		laser_grant     = 1'b0;
		rec_num         = 0;
		load_scenarios();
		loaded = 1'b1;
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
		foreach (scenarios[i])
		begin
			rec_num = i + 1;
			@(posedge clk);
			apply_record(scenarios[i]);
			run_record(scenarios[i]);
		end
		$display("Regression passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- tests/tank_arena_tests.txt
# en rsp slot px py pdir bv bx by fg lg wait  ex ey edir alive score sv hit
# dir 0 up 1 down 2 left 3 right, wait is clk edges after the inputs change
# respawn at each corner, a player bullet kills in between
1 1 0 12  6 0 0  0  0 0 0  1   0  0 1 1 0 0 0
1 0 0 12  6 0 1  0  0 0 0  1   0  0 1 0 1 0 0
1 1 1 12  6 0 0  0  0 0 0  1  24  0 1 1 1 0 0
1 0 1 12  6 0 1 24  0 0 0  1  24  0 1 0 2 0 0
1 1 2 12  6 0 0  0  0 0 0  1   0 12 1 1 2 0 0
1 0 2 12  6 0 1  0 12 0 0  1   0 12 1 0 3 0 0
1 1 3 12  6 0 0  0  0 0 0  1  24 12 1 1 3 0 0
# chase along the row, the second shell flies left into the player
1 0 3 20 12 0 0  0  0 0 0  7  22 12 2 1 3 1 0
1 0 3 20 12 0 0  0  0 0 0  3  21 12 2 1 3 0 1
# chase on a diagonal, ties step vertically
1 0 3 17  8 0 0  0  0 0 0  7  21 10 0 1 3 0 0
# chase up the column with a shell ahead of the tank
1 0 3 21  4 0 0  0  0 0 0 11  21  7 0 1 3 1 0
1 0 3 21  4 0 0  0  0 0 0  1  21  7 0 1 3 0 1
# player drives onto the enemy cell
1 0 3 21  7 0 0  0  0 0 0  1  21  7 0 0 4 0 0
# respawn with a freeze grant, then the chase resumes
1 1 0 10  5 0 0  0  0 1 0 23   0  0 1 1 4 0 0
1 0 0 10  5 0 0  0  0 0 0  3   0  1 1 1 4 0 0
# laser with the player facing away, then facing the enemy
1 0 0  6  1 3 0  0  0 0 1  3   1  1 3 1 4 1 0
1 0 0  6  1 2 0  0  0 0 0  1   1  1 3 0 5 1 0
# game disabled, score clears and the shell holds
0 0 0  6  1 2 0  0  0 0 0  2   1  1 3 0 0 1 0

//--- tank_arena.f
common/tank_pkg.sv
common/tank_pos_if.sv
enemy_tank/enemy_tank_ctrl.sv
enemy_tank/enemy_hit_judge.sv
design/game_tick.sv
design/reward_regs.sv
design/enemy_shell.sv
design/tank_arena_top.sv
tests/tank_arena_tb.sv
